//--- i2cPkg.sv
package i2cPkg;

    // ======================================================================
    // Bus field types
    // ======================================================================
    typedef logic [6:0]  slaveAddrT;
    typedef logic [15:0] regAddrT;
    typedef logic [15:0] regDataT;
    typedef logic [7:0]  byteT;

    // ======================================================================
    // Sequencer states, one per bus phase
    // ======================================================================
    typedef enum logic [3:0] {
        seqIdle,
        seqStart,
        seqAddr,
        seqRegHigh,
        seqRegLow,
        seqWriteHigh,
        seqWriteLow,
        seqRestart,
        seqReadAddr,
        seqReadBit,
        seqMasterAck,
        seqStop,
        seqResponse
    } seqStateT;

    // Integer divide, rounded up
    function automatic int divCeil(int num, int den);
        return (num + den - 1) / den;
    endfunction

endpackage

//--- quarterTimer.sv
`timescale 1ns/1ps

module quarterTimer #(
    parameter int QuarterTicks = 2
) (
    input  logic clk,
    input  logic arstN,
    input  logic timerStart,
    output logic quarterDone
);

    // At least one bit, even for a single-cycle quarter
    localparam int CntW = (QuarterTicks > 0) ? $clog2(QuarterTicks + 1) : 1;

    logic [CntW-1:0] count;
    logic            running;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count   <= '0;
            running <= 1'b0;
        end else if (timerStart) begin
            count   <= CntW'(QuarterTicks);
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // One cycle wide, QuarterTicks+1 cycles after the start edge
    assign quarterDone = running && (count == '0);

endmodule

//--- txShifter.sv
`timescale 1ns/1ps

module txShifter
    import i2cPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic txLoad,
    input  byteT txByte,
    input  logic txShift,
    input  logic txForce,
    input  logic txLevel,
    output logic sdaLow,
    output logic lastBit
);

    byteT       shiftReg;
    logic [2:0] bitCnt;

    // Byte being sent, MSB is on the wire
    always_ff @(posedge clk) begin
        if (txLoad) begin
            shiftReg <= txByte;
        end else if (txShift) begin
            shiftReg <= shiftReg << 1;
        end
    end

    // Open-drain output, high means pull SDA low
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sdaLow <= 1'b0;
            bitCnt <= '0;
        end else if (txForce) begin
            sdaLow <= !txLevel;
        end else if (txLoad) begin
            sdaLow <= !txByte[7];
            bitCnt <= '0;
        end else if (txShift) begin
            sdaLow <= !shiftReg[6];
            bitCnt <= bitCnt + 3'd1;
        end
    end

    // Eighth bit on the wire, next slot is the slave acknowledge
    assign lastBit = (bitCnt == 3'd7);

endmodule

//--- rxShifter.sv
`timescale 1ns/1ps

module rxShifter
    import i2cPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    sdaIn,
    input  logic    rxClear,
    input  logic    rxSample,
    output logic    sdaBit,
    output regDataT rxWord,
    output logic    byteFull
);

    logic       sdaMeta;
    logic [2:0] bitCnt;

    // Two-flop synchronizer, idle bus level is high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sdaMeta <= 1'b1;
            sdaBit  <= 1'b1;
        end else begin
            sdaMeta <= sdaIn;
            sdaBit  <= sdaMeta;
        end
    end

    // Bit count within the current byte
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            byteFull <= 1'b0;
        end else if (rxClear) begin
            bitCnt   <= '0;
            byteFull <= 1'b0;
        end else if (rxSample) begin
            bitCnt   <= bitCnt + 3'd1;
            byteFull <= (bitCnt == 3'd7);
        end
    end

    // Received bits enter at the LSB, so the data ends up right-aligned
    always_ff @(posedge clk) begin
        if (rxClear) begin
            rxWord <= '0;
        end else if (rxSample) begin
            rxWord <= {rxWord[14:0], sdaBit};
        end
    end

endmodule

//--- i2cSequencer.sv
`timescale 1ns/1ps

module i2cSequencer
    import i2cPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      cmdValid,
    output logic      cmdReady,
    input  slaveAddrT cmdSlaveAddr,
    input  logic      cmdWrite,
    input  regAddrT   cmdRegAddr,
    input  logic      cmdTwoBytes,
    input  regDataT   cmdWriteData,
    output logic      rspValid,
    input  logic      rspReady,
    output logic      rspErr,
    output regDataT   rspReadData,
    output logic      scl,
    input  logic      quarterDone,
    output logic      timerStart,
    output logic      txLoad,
    output byteT      txByte,
    output logic      txShift,
    output logic      txForce,
    output logic      txLevel,
    input  logic      lastBit,
    output logic      rxClear,
    output logic      rxSample,
    input  logic      sdaBit,
    input  regDataT   rxWord,
    input  logic      byteFull
);

    seqStateT   state;
    seqStateT   afterAck;
    logic [1:0] phase;
    slaveAddrT  slaveAddr;
    logic       isWrite;
    regAddrT    regAddr;
    logic       twoBytes;
    regDataT    writeData;
    logic       moreBytes;
    logic       loadPending;
    logic       ackSlot;
    logic       nack;
    logic       accept;
    logic       sendByte;

    assign accept      = (state == seqIdle) && cmdValid;
    assign cmdReady    = (state == seqIdle);
    assign rspReadData = rxWord;

    // Bus actions come one quarter apart, none after the stop condition
    assign timerStart = accept || (quarterDone && !(state == seqStop && phase == 2'd3));

    assign sendByte = (state == seqAddr) || (state == seqRegHigh) || (state == seqRegLow) ||
                      (state == seqWriteHigh) || (state == seqWriteLow) ||
                      (state == seqReadAddr);

    // Captured command fields
    always_ff @(posedge clk) begin
        if (accept) begin
            slaveAddr <= cmdSlaveAddr;
            isWrite   <= cmdWrite;
            regAddr   <= cmdRegAddr;
            twoBytes  <= cmdTwoBytes;
            writeData <= cmdWriteData;
        end
    end

    // ======================================================================
    // Byte to send and the phase that follows its acknowledge
    // ======================================================================
    always_comb begin
        case (state)
            seqRegHigh:   txByte = regAddr[15:8];
            seqRegLow:    txByte = regAddr[7:0];
            seqWriteHigh: txByte = writeData[15:8];
            seqWriteLow:  txByte = writeData[7:0];
            seqReadAddr:  txByte = {slaveAddr, 1'b1};
            default:      txByte = {slaveAddr, 1'b0};
        endcase
    end

    always_comb begin
        case (state)
            seqAddr:      afterAck = seqRegHigh;
            seqRegHigh:   afterAck = seqRegLow;
            seqWriteHigh: afterAck = seqWriteLow;
            seqReadAddr:  afterAck = seqReadBit;
            seqRegLow: begin
                if (!isWrite) begin
                    afterAck = seqRestart;
                end else begin
                    afterAck = twoBytes ? seqWriteHigh : seqWriteLow;
                end
            end
            default:      afterAck = seqStop;
        endcase
    end

    // ======================================================================
    // SDA actions, taken while SCL is low (p0) or high (p2)
    // ======================================================================
    always_comb begin
        txLoad   = 1'b0;
        txShift  = 1'b0;
        txForce  = 1'b0;
        txLevel  = 1'b1;
        rxClear  = 1'b0;
        rxSample = 1'b0;
        if (accept) begin
            // Start condition
            txForce = 1'b1;
            txLevel = 1'b0;
        end else if (quarterDone && phase == 2'd0) begin
            case (state)
                seqRestart,
                seqReadBit: txForce = 1'b1;
                seqMasterAck: begin
                    txForce = 1'b1;
                    txLevel = !moreBytes;
                end
                seqStop: begin
                    txForce = 1'b1;
                    txLevel = 1'b0;
                end
                default: begin
                    if (sendByte && ackSlot) begin
                        txForce = 1'b1;
                    end else if (sendByte && loadPending) begin
                        txLoad = 1'b1;
                    end else if (sendByte) begin
                        txShift = 1'b1;
                    end
                end
            endcase
        end else if (quarterDone && phase == 2'd2) begin
            case (state)
                seqRestart: begin
                    txForce = 1'b1;
                    txLevel = 1'b0;
                    rxClear = 1'b1;
                end
                seqStop:    txForce = 1'b1;
                seqReadBit: rxSample = 1'b1;
                default:    ;
            endcase
        end
    end

    // ======================================================================
    // State, SCL and transaction flags
    // ======================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= seqIdle;
            phase       <= 2'd0;
            scl         <= 1'b1;
            rspValid    <= 1'b0;
            rspErr      <= 1'b0;
            moreBytes   <= 1'b0;
            loadPending <= 1'b0;
            ackSlot     <= 1'b0;
            nack        <= 1'b0;
        end else if (accept) begin
            state     <= seqStart;
            phase     <= 2'd0;
            nack      <= 1'b0;
            moreBytes <= cmdTwoBytes;
        end else if (state == seqResponse) begin
            if (rspReady) begin
                rspValid <= 1'b0;
                state    <= seqIdle;
            end
        end else if (quarterDone) begin
            phase <= phase + 2'd1;
            if (phase == 2'd1) begin
                scl <= 1'b1;
            end
            if (phase == 2'd3 && state != seqStop) begin
                scl <= 1'b0;
            end

            if (state == seqStart) begin
                // SCL low after the start condition
                scl         <= 1'b0;
                phase       <= 2'd0;
                state       <= seqAddr;
                loadPending <= 1'b1;
                ackSlot     <= 1'b0;
            end else if (sendByte) begin
                if (phase == 2'd0 && !ackSlot) begin
                    loadPending <= 1'b0;
                end
                // Slave acknowledge at mid-high of the ninth clock
                if (phase == 2'd2 && ackSlot) begin
                    nack <= sdaBit;
                end
                if (phase == 2'd3 && ackSlot) begin
                    ackSlot     <= 1'b0;
                    loadPending <= 1'b1;
                    state       <= nack ? seqStop : afterAck;
                end else if (phase == 2'd3 && lastBit) begin
                    ackSlot <= 1'b1;
                end
            end else if (phase == 2'd3) begin
                case (state)
                    seqRestart: state <= seqReadAddr;
                    seqReadBit: begin
                        if (byteFull) begin
                            state <= seqMasterAck;
                        end
                    end
                    seqMasterAck: begin
                        moreBytes <= 1'b0;
                        state     <= moreBytes ? seqReadBit : seqStop;
                    end
                    seqStop: begin
                        state    <= seqResponse;
                        rspValid <= 1'b1;
                        rspErr   <= nack;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- sensorI2cMaster.sv
`timescale 1ns/1ps

module sensorI2cMaster
    import i2cPkg::*;
#(
    parameter int ClkFreq = 24_000_000,
    parameter int I2cFreq = 400_000
) (
    input  logic      clk,
    input  logic      arstN,
    input  logic      cmdValid,
    output logic      cmdReady,
    input  slaveAddrT cmdSlaveAddr,
    input  logic      cmdWrite,
    input  regAddrT   cmdRegAddr,
    input  logic      cmdTwoBytes,
    input  regDataT   cmdWriteData,
    output logic      rspValid,
    input  logic      rspReady,
    output logic      rspErr,
    output regDataT   rspReadData,
    output logic      scl,
    output logic      sdaLow,
    input  logic      sdaIn
);

    // Quarter bus period in clk cycles, rounded up so the bus is never too fast
    localparam int QuarterTicks = divCeil(ClkFreq, 4 * I2cFreq) - 1;

    logic    timerStart;
    logic    quarterDone;
    logic    txLoad;
    byteT    txByte;
    logic    txShift;
    logic    txForce;
    logic    txLevel;
    logic    lastBit;
    logic    rxClear;
    logic    rxSample;
    logic    sdaBit;
    regDataT rxWord;
    logic    byteFull;

    quarterTimer #(
        .QuarterTicks(QuarterTicks)
    ) timer (
        .clk        (clk),
        .arstN      (arstN),
        .timerStart (timerStart),
        .quarterDone(quarterDone)
    );

    txShifter tx (
        .clk    (clk),
        .arstN  (arstN),
        .txLoad (txLoad),
        .txByte (txByte),
        .txShift(txShift),
        .txForce(txForce),
        .txLevel(txLevel),
        .sdaLow (sdaLow),
        .lastBit(lastBit)
    );

    rxShifter rx (
        .clk     (clk),
        .arstN   (arstN),
        .sdaIn   (sdaIn),
        .rxClear (rxClear),
        .rxSample(rxSample),
        .sdaBit  (sdaBit),
        .rxWord  (rxWord),
        .byteFull(byteFull)
    );

    i2cSequencer seq (
        .clk         (clk),
        .arstN       (arstN),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .cmdSlaveAddr(cmdSlaveAddr),
        .cmdWrite    (cmdWrite),
        .cmdRegAddr  (cmdRegAddr),
        .cmdTwoBytes (cmdTwoBytes),
        .cmdWriteData(cmdWriteData),
        .rspValid    (rspValid),
        .rspReady    (rspReady),
        .rspErr      (rspErr),
        .rspReadData (rspReadData),
        .scl         (scl),
        .quarterDone (quarterDone),
        .timerStart  (timerStart),
        .txLoad      (txLoad),
        .txByte      (txByte),
        .txShift     (txShift),
        .txForce     (txForce),
        .txLevel     (txLevel),
        .lastBit     (lastBit),
        .rxClear     (rxClear),
        .rxSample    (rxSample),
        .sdaBit      (sdaBit),
        .rxWord      (rxWord),
        .byteFull    (byteFull)
    );

endmodule

//--- i2cSlaveModel.sv
`timescale 1ns/1ps

module i2cSlaveModel
    import i2cPkg::*;
#(
    parameter slaveAddrT DevAddr = 7'h36
) (
    input  logic clk,
    input  logic arstN,
    input  logic scl,
    input  logic sda,
    output logic sdaLow
);

    byteT       regs [256];
    byteT       rxByte;
    byteT       txByte;
    byteT       regPtr;
    logic       sclPrev;
    logic       sdaPrev;
    logic [3:0] bitCnt;
    logic [2:0] byteIdx;
    logic       selected;
    logic       reading;
    logic       sending;
    logic       masterAck;

    logic startCond;
    logic stopCond;
    logic sclRise;
    logic sclFall;

    // Bus events, oversampled on clk
    assign startCond = sclPrev && scl && sdaPrev && !sda;
    assign stopCond  = sclPrev && scl && !sdaPrev && sda;
    assign sclRise   = !sclPrev && scl;
    assign sclFall   = sclPrev && !scl;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 256; i++) begin
                regs[i] <= 8'(i) ^ 8'hA5;
            end
            rxByte    <= '0;
            txByte    <= '0;
            regPtr    <= '0;
            sclPrev   <= 1'b1;
            sdaPrev   <= 1'b1;
            bitCnt    <= '0;
            byteIdx   <= '0;
            selected  <= 1'b0;
            reading   <= 1'b0;
            sending   <= 1'b0;
            masterAck <= 1'b0;
            sdaLow    <= 1'b0;
        end else begin
            sclPrev <= scl;
            sdaPrev <= sda;
            if (startCond || stopCond) begin
                // Register pointer survives a repeated start
                bitCnt   <= '0;
                byteIdx  <= '0;
                selected <= 1'b0;
                reading  <= 1'b0;
                sending  <= 1'b0;
                sdaLow   <= 1'b0;
            end else if (sclRise) begin
                bitCnt <= bitCnt + 4'd1;
                if (bitCnt < 4'd8) begin
                    rxByte <= {rxByte[6:0], sda};
                end else begin
                    masterAck <= !sda;
                end
            end else if (sclFall) begin
                if (bitCnt == 4'd8) begin
                    // Full byte in, answer during the ninth clock
                    if (byteIdx == 3'd0) begin
                        selected <= (rxByte[7:1] == DevAddr);
                        reading  <= rxByte[0];
                        sdaLow   <= (rxByte[7:1] == DevAddr);
                    end else if (reading || !selected) begin
                        sdaLow <= 1'b0;
                    end else begin
                        sdaLow <= 1'b1;
                        if (byteIdx == 3'd2) begin
                            regPtr <= rxByte;
                        end else if (byteIdx >= 3'd3) begin
                            regs[regPtr] <= rxByte;
                            regPtr       <= regPtr + 8'd1;
                        end
                    end
                end else if (bitCnt == 4'd9) begin
                    bitCnt  <= '0;
                    byteIdx <= byteIdx + 3'd1;
                    if (selected && reading && (byteIdx == 3'd0 || masterAck)) begin
                        sending <= 1'b1;
                        txByte  <= regs[regPtr];
                        sdaLow  <= !regs[regPtr][7];
                        regPtr  <= regPtr + 8'd1;
                    end else begin
                        sending <= 1'b0;
                        sdaLow  <= 1'b0;
                    end
                end else if (sending && bitCnt != 4'd0) begin
                    txByte <= txByte << 1;
                    sdaLow <= !txByte[6];
                end
            end
        end
    end

endmodule

//--- tbSensorI2cMaster.sv
`timescale 1ns/1ps

module tbSensorI2cMaster
    import i2cPkg::*;
;

    localparam int        ClkFreq      = 24_000_000;
    localparam int        I2cFreq      = 2_000_000;
    localparam int        QuarterTicks = divCeil(ClkFreq, 4 * I2cFreq) - 1;
    localparam slaveAddrT ModelAddr    = 7'h36;
    localparam int        StallCycles  = 60;
    // Worst case is a two-byte read of about 57 bit periods
    localparam int        NumCmds      = 50;
    localparam int        WorstBits    = 60;
    localparam int        TimeoutLimit = NumCmds * WorstBits * 4 * (QuarterTicks + 1)
                                         + StallCycles + 2000;

    logic      clk;
    logic      arstN;
    logic      cmdValid;
    logic      cmdReady;
    slaveAddrT cmdSlaveAddr;
    logic      cmdWrite;
    regAddrT   cmdRegAddr;
    logic      cmdTwoBytes;
    regDataT   cmdWriteData;
    logic      rspValid;
    logic      rspReady;
    logic      rspErr;
    regDataT   rspReadData;
    logic      scl;
    logic      masterSdaLow;
    logic      modelSdaLow;
    logic      sdaBus;

    byteT    shadow [256];
    logic    expErrQ [$];
    regDataT expDataQ [$];
    logic    checkDataQ [$];
    int      errorCount;
    int      rspCount;
    int      sclPulses;
    int      highCount;
    int      cycleCount;
    logic    measuring;
    logic    sclLast;
    logic    rspSeen;
    integer  seed;

    // Open-drain bus is low when either side pulls
    assign sdaBus = !(masterSdaLow || modelSdaLow);

    sensorI2cMaster #(
        .ClkFreq(ClkFreq),
        .I2cFreq(I2cFreq)
    ) UUT (
        .clk         (clk),
        .arstN       (arstN),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .cmdSlaveAddr(cmdSlaveAddr),
        .cmdWrite    (cmdWrite),
        .cmdRegAddr  (cmdRegAddr),
        .cmdTwoBytes (cmdTwoBytes),
        .cmdWriteData(cmdWriteData),
        .rspValid    (rspValid),
        .rspReady    (rspReady),
        .rspErr      (rspErr),
        .rspReadData (rspReadData),
        .scl         (scl),
        .sdaLow      (masterSdaLow),
        .sdaIn       (sdaBus)
    );

    i2cSlaveModel #(
        .DevAddr(ModelAddr)
    ) sensor (
        .clk   (clk),
        .arstN (arstN),
        .scl   (scl),
        .sda   (sdaBus),
        .sdaLow(modelSdaLow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    // ======================================================================
    // Reference model and compare tasks
    // ======================================================================
    function automatic logic [16:0] expectedResponse(slaveAddrT addr, regAddrT regA,
                                                     logic two);
        byteT    low;
        regDataT data;
        low = regA[7:0];
        if (two) begin
            data = {shadow[low], shadow[low + 8'd1]};
        end else begin
            data = {8'h00, shadow[low]};
        end
        return {addr != ModelAddr, data};
    endfunction

    task automatic checkData(input string name, input regDataT got, input regDataT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // ======================================================================
    // Command side
    // ======================================================================
    task automatic sendCommand(input slaveAddrT addr, input logic write, input regAddrT regA,
                               input logic two, input regDataT data);
        logic [16:0] expRsp;
        byteT        low;
        expRsp = expectedResponse(addr, regA, two);
        low    = regA[7:0];
        expErrQ.push_back(expRsp[16]);
        expDataQ.push_back(expRsp[15:0]);
        checkDataQ.push_back(!write && !expRsp[16]);
        if (write && !expRsp[16]) begin
            if (two) begin
                shadow[low]        = data[15:8];
                shadow[low + 8'd1] = data[7:0];
            end else begin
                shadow[low] = data[7:0];
            end
        end
        @(negedge clk);
        cmdSlaveAddr = addr;
        cmdWrite     = write;
        cmdRegAddr   = regA;
        cmdTwoBytes  = two;
        cmdWriteData = data;
        cmdValid     = 1'b1;
        while (!cmdReady) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmdValid = 1'b0;
    endtask

    task automatic runCommand(input slaveAddrT addr, input logic write, input regAddrT regA,
                              input logic two, input regDataT data);
        sendCommand(addr, write, regA, two, data);
        while (!rspValid) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // Each response is checked once on the first falling edge where it is visible
    always @(negedge clk) begin
        if (rspValid && !rspSeen) begin
            rspSeen = 1'b1;
            rspCount++;
            if (expErrQ.size() == 0) begin
                $display("Response arrived without a command at %0t ns", $time);
                errorCount++;
            end else begin
                checkFlag("rspErr", rspErr, expErrQ.pop_front());
                if (checkDataQ.pop_front()) begin
                    checkData("rspReadData", rspReadData, expDataQ.pop_front());
                end else begin
                    void'(expDataQ.pop_front());
                end
            end
        end else if (!rspValid) begin
            rspSeen = 1'b0;
        end
    end

    // SCL high time of pulses fully inside a transaction
    always @(negedge clk) begin
        if (!arstN || cmdReady || rspValid) begin
            measuring = 1'b0;
        end else if (scl && !sclLast) begin
            measuring = 1'b1;
            highCount = 1;
        end else if (scl && measuring) begin
            highCount++;
        end else if (!scl && sclLast && measuring) begin
            checkCount("scl high cycles", highCount, 2 * (QuarterTicks + 1));
            sclPulses++;
            measuring = 1'b0;
        end
        sclLast = scl;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
            $display("Something failed");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        regDataT   heldData;
        integer    r;
        slaveAddrT addr;
        cmdValid     = 1'b0;
        cmdSlaveAddr = '0;
        cmdWrite     = 1'b0;
        cmdRegAddr   = '0;
        cmdTwoBytes  = 1'b0;
        cmdWriteData = '0;
        rspReady     = 1'b1;
        arstN        = 1'b0;
        errorCount   = 0;
        rspCount     = 0;
        sclPulses    = 0;
        highCount    = 0;
        cycleCount   = 0;
        measuring    = 1'b0;
        sclLast      = 1'b1;
        rspSeen      = 1'b0;
        seed         = 14634;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'(i) ^ 8'hA5;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkFlag("cmdReady", cmdReady, 1'b1);
        checkFlag("rspValid", rspValid, 1'b0);
        checkFlag("scl", scl, 1'b1);
        checkFlag("sdaLow", masterSdaLow, 1'b0);

        // Single byte write and read back
        runCommand(ModelAddr, 1'b1, 16'h3012, 1'b0, 16'h005C);
        runCommand(ModelAddr, 1'b0, 16'h3012, 1'b0, 16'h0000);

        // Two bytes land at N and N+1
        runCommand(ModelAddr, 1'b1, 16'h3020, 1'b1, 16'hBEEF);
        runCommand(ModelAddr, 1'b0, 16'h3020, 1'b1, 16'h0000);
        runCommand(ModelAddr, 1'b0, 16'h3021, 1'b0, 16'h0000);

        // Wrong device leaves the register as it was
        runCommand(7'h37, 1'b1, 16'h3030, 1'b0, 16'h0011);
        runCommand(ModelAddr, 1'b0, 16'h3030, 1'b0, 16'h0000);

        // Response held back by the host
        rspReady = 1'b0;
        heldData = regDataT'(expectedResponse(ModelAddr, 16'h3020, 1'b1));
        sendCommand(ModelAddr, 1'b0, 16'h3020, 1'b1, 16'h0000);
        while (!rspValid) begin
            @(negedge clk);
        end
        repeat (StallCycles) begin
            checkFlag("rspValid", rspValid, 1'b1);
            checkData("rspReadData", rspReadData, heldData);
            checkFlag("cmdReady", cmdReady, 1'b0);
            checkFlag("scl", scl, 1'b1);
            checkFlag("sdaLow", masterSdaLow, 1'b0);
            @(negedge clk);
        end
        rspReady = 1'b1;
        @(negedge clk);

        // Random traffic with about one in ten to a wrong device
        for (int n = 0; n < 40; n++) begin
            r    = $random(seed);
            addr = ModelAddr;
            if (r[15:8] < 8'd26) begin
                addr = ModelAddr ^ slaveAddrT'(r[22:16] | 7'h01);
            end
            runCommand(addr, r[0], regAddrT'($random(seed)), r[1], regDataT'($random(seed)));
        end

        repeat (10) @(negedge clk);
        if (expErrQ.size() != 0) begin
            $display("%0d commands never got a response", expErrQ.size());
            errorCount++;
        end
        if (sclPulses == 0) begin
            $display("No SCL high pulse was measured");
            errorCount++;
        end
        $display("Checked %0d responses and %0d SCL pulses, %0d errors",
                 rspCount, sclPulses, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sensorI2cMaster.f
i2cPkg.sv
quarterTimer.sv
txShifter.sv
rxShifter.sv
i2cSequencer.sv
sensorI2cMaster.sv
i2cSlaveModel.sv
tbSensorI2cMaster.sv

//--- runSim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbSensorI2cMaster \
    -f sensorI2cMaster.f -o simTb
./obj_dir/simTb > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
